//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dcache
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_ADDR_W          32
`define DC_WORD_W          32
`define DC_BYTES           4
`define DC_WAYS            4
`define DC_SETS            16
`define DC_WORDS_PER_LINE  4

// address fields, low to high: align, offset, index, tag
`define DC_ALIGN_BITS   ($clog2(`DC_BYTES))
`define DC_OFFSET_BITS  ($clog2(`DC_WORDS_PER_LINE))
`define DC_INDEX_BITS   ($clog2(`DC_SETS))
`define DC_WAY_BITS     ($clog2(`DC_WAYS))
`define DC_TAG_BITS     (`DC_ADDR_W - `DC_INDEX_BITS - `DC_OFFSET_BITS - `DC_ALIGN_BITS)

`endif

//--- sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // high resets; released after the last reset edge
    initial begin
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_checker (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  req_valid,
    input  logic                  req_ready,
    input  logic [`DC_ADDR_W-1:0] req_addr,
    input  logic                  req_write,
    input  logic [`DC_BYTES-1:0]  req_strobe,
    input  logic [`DC_WORD_W-1:0] req_wdata,
    input  logic                  resp_valid,
    input  logic                  resp_ready,
    input  logic [`DC_WORD_W-1:0] resp_rdata,
    input  logic                  mem_req_valid,
    input  logic                  mem_req_write,
    input  logic [`DC_ADDR_W-1:0] mem_req_addr,
    input  logic [`DC_WORD_W-1:0] mem_wdata,
    input  logic                  mem_ready,
    input  logic                  mem_last,
    output int                    errors,
    output int                    pending,
    output int                    responses,
    output int                    rd_bursts,
    output int                    wr_bursts
);

    logic [31:0] shadow [logic [31:0]];
    logic [31:0] expect_q [$];
    logic [31:0] held_word;
    logic        held;
    logic        in_reset_window = 1'b0;
    int          reset_errors = 0;
    int          compare_errors;
    int          wb_beat;

    assign errors = reset_errors + compare_errors;

    // same fill pattern as the memory model
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return initial_word(addr);
    endfunction

    // a store returns the stored word with its strobed bytes laid over it
    function automatic logic [31:0] expected_word(
        input logic [31:0] addr,
        input logic        write,
        input logic [3:0]  strobe,
        input logic [31:0] wdata
    );
        logic [31:0] mask;
        mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
        if (!write) begin
            return shadow_word(addr);
        end
        return (shadow_word(addr) & ~mask) | (wdata & mask);
    endfunction

    task automatic report_mismatch(
        input string       signal,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        $display("[FAIL] %0t %s expected %h got %h", $time, signal, expected, actual);
        compare_errors++;
    endtask

    // outputs quiet during reset and on the cycle after
    always @(negedge clk) begin
        if (in_reset_window) begin
            if ({req_ready, resp_valid, mem_req_valid} !== 3'b000) begin
                $display("[FAIL] %0t req_ready,resp_valid,mem_req_valid expected 000 got %b%b%b",
                         $time, req_ready, resp_valid, mem_req_valid);
                reset_errors++;
            end
        end
        in_reset_window = resetn;
    end

    always @(posedge clk) begin
        logic [31:0] exp_word;
        logic [31:0] addr;
        if (resetn) begin
            expect_q.delete();
            held           = 1'b0;
            held_word      = '0;
            wb_beat        = 0;
            compare_errors = 0;
            pending        = 0;
            responses      = 0;
            rd_bursts      = 0;
            wr_bursts      = 0;
        end else begin
            if (req_valid && req_ready) begin
                addr     = {req_addr[31:2], 2'b00};
                exp_word = expected_word(addr, req_write, req_strobe, req_wdata);
                expect_q.push_back(exp_word);
                if (req_write) begin
                    shadow[addr] = exp_word;
                end
            end
            if (resp_valid && resp_ready) begin
                if (expect_q.size() == 0) begin
                    $display("error at %0t: a response arrived with no request outstanding",
                             $time);
                    compare_errors++;
                end else begin
                    exp_word = expect_q.pop_front();
                    if (resp_rdata !== exp_word) begin
                        report_mismatch("resp_rdata", exp_word, resp_rdata);
                    end
                end
                responses++;
            end
            if (held && (resp_rdata !== held_word)) begin
                report_mismatch("resp_rdata while stalled", held_word, resp_rdata);
            end
            held      = resp_valid && !resp_ready;
            held_word = resp_rdata;
            // written-back words must match the shadow copy
            if (mem_req_valid && mem_ready) begin
                if (mem_req_write) begin
                    exp_word = shadow_word(mem_req_addr + 32'(wb_beat * 4));
                    if (mem_wdata !== exp_word) begin
                        report_mismatch("mem_wdata", exp_word, mem_wdata);
                    end
                end
                if (mem_last) begin
                    wb_beat = 0;
                    if (mem_req_write) begin
                        wr_bursts++;
                    end else begin
                        rd_bursts++;
                    end
                end else begin
                    wb_beat++;
                end
            end
            pending = expect_q.size();
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module tb_dcache;

    localparam int SEED       = 41276;
    localparam int PERIOD_NS  = 40;
    localparam int N_REQUESTS = 2 + 30 + 10 + 40 + 400;
    localparam int TIMEOUT_NS = N_REQUESTS * 40 * PERIOD_NS + 20000;

    logic                  clk;
    logic                  resetn;
    logic                  req_valid = 1'b0;
    logic [`DC_ADDR_W-1:0] req_addr = '0;
    logic                  req_write = 1'b0;
    logic [`DC_BYTES-1:0]  req_strobe = '0;
    logic [`DC_WORD_W-1:0] req_wdata = '0;
    logic                  req_ready;
    logic                  resp_valid;
    logic [`DC_WORD_W-1:0] resp_rdata;
    logic                  resp_ready = 1'b1;
    logic                  mem_req_valid;
    logic                  mem_req_write;
    logic [`DC_ADDR_W-1:0] mem_req_addr;
    logic [`DC_WORD_W-1:0] mem_wdata;
    logic                  mem_ready = 1'b0;
    logic [`DC_WORD_W-1:0] mem_rdata = '0;
    logic                  mem_last = 1'b0;

    int          stim_seed = SEED;
    int          bus_seed = SEED;
    logic        resp_random = 1'b0;
    int          mem_beat = 0;
    logic [31:0] mem_store [logic [31:0]];
    int          check_errors;
    int          pending;
    int          responses;
    int          rd_bursts;
    int          wr_bursts;
    int          count_errors;
    int          errors_before;
    int          test_num;

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) i_clock_gen (
        .clk    (clk),
        .resetn (resetn)
    );

    dcache_top i_dcache_top (.*);

    dcache_checker i_dcache_checker (.*, .errors(check_errors));

    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        if (mem_store.exists(addr)) begin
            return mem_store[addr];
        end
        return initial_word(addr);
    endfunction

    // memory model and response sink driven on the falling edge
    always @(negedge clk) begin
        mem_ready = 1'b0;
        mem_last  = 1'b0;
        if (mem_req_valid === 1'b1) begin
            mem_ready = ($random(bus_seed) & 3) != 0;
            mem_rdata = memory_word(mem_req_addr + 32'(mem_beat * 4));
            mem_last  = (mem_beat == 3);
        end
        if (resp_random) begin
            resp_ready = ($random(bus_seed) & 1) == 0;
        end else begin
            resp_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!resetn && mem_req_valid && mem_ready) begin
            if (mem_req_write) begin
                mem_store[mem_req_addr + 32'(mem_beat * 4)] = mem_wdata;
            end
            mem_beat = mem_last ? 0 : mem_beat + 1;
        end
    end

    // called and returns on a falling edge
    task automatic cpu_access(
        input logic [31:0] addr,
        input logic        write,
        input logic [3:0]  strobe,
        input logic [31:0] wdata
    );
        req_valid  = 1'b1;
        req_addr   = addr;
        req_write  = write;
        req_strobe = strobe;
        req_wdata  = wdata;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // 8 tags over 4 sets so lines get evicted often
    task automatic random_access();
        logic [31:0] r;
        logic [31:0] addr;
        r    = $random(stim_seed);
        addr = 32'h0004_0000 | (32'(r[2:0]) << 8) | (32'(r[4:3]) << 4) | (32'(r[6:5]) << 2);
        if (r[13:12] == 2'b00) begin
            @(negedge clk);
        end
        cpu_access(addr, r[7], r[11:8], $random(stim_seed));
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_count(input string signal, input int expected, input int actual);
        if (actual != expected) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, signal, expected, actual);
            count_errors++;
        end
    endtask

    task automatic report_test(input string name);
        int total;
        total = check_errors + count_errors;
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, total - errors_before);
        errors_before = total;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int rd_before;
        int wr_before;
        int total;
        count_errors  = 0;
        errors_before = 0;
        test_num      = 0;
        wait (resetn == 1'b0);
        repeat (2) @(negedge clk);
        report_test("reset");

        rd_before = rd_bursts;
        wr_before = wr_bursts;
        cpu_access(32'h0000_1044, 1'b0, 4'h0, 32'h0);
        wait_drained();
        expect_count("rd_bursts", rd_before + 1, rd_bursts);
        cpu_access(32'h0000_1048, 1'b0, 4'h0, 32'h0);
        wait_drained();
        expect_count("rd_bursts", rd_before + 1, rd_bursts);
        expect_count("wr_bursts", wr_before, wr_bursts);
        report_test("load miss then hit");

        for (int s = 1; s < 16; s++) begin
            cpu_access(32'h0000_2084, 1'b1, 4'(s), $random(stim_seed));
            cpu_access(32'h0000_2084, 1'b0, 4'h0, 32'h0);
        end
        wait_drained();
        report_test("byte strobes");

        // five tags in set 3 overflow the four ways
        wr_before = wr_bursts;
        for (int t = 0; t < 5; t++) begin
            cpu_access(32'h0000_1030 + 32'(t) * 32'h100 + 32'(t % 4) * 4, 1'b1, 4'hf,
                       $random(stim_seed));
        end
        for (int t = 0; t < 5; t++) begin
            cpu_access(32'h0000_1030 + 32'(t) * 32'h100 + 32'(t % 4) * 4, 1'b0, 4'h0, 32'h0);
        end
        wait_drained();
        if (wr_bursts <= wr_before) begin
            $display("error at %0t: five stores to one set caused no write burst", $time);
            count_errors++;
        end
        report_test("dirty eviction");

        resp_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            random_access();
        end
        wait_drained();
        report_test("response back-pressure");

        for (int i = 0; i < 400; i++) begin
            random_access();
        end
        while (responses < N_REQUESTS) begin
            @(negedge clk);
        end
        // a few idle cycles let a stray response show up
        repeat (4) @(negedge clk);
        expect_count("pending", 0, pending);
        expect_count("responses", N_REQUESTS, responses);
        report_test("random mix");

        total = check_errors + count_errors;
        $display("tests %0d, requests %0d, responses %0d, errors %0d",
                 test_num, N_REQUESTS, responses, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
src/dcache_pkg.sv
src/cache_ram.sv
src/plru_tree.sv
src/tag_lookup.sv
src/miss_controller.sv
src/dcache_response.sv
src/dcache_top.sv
sim/clock_gen.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

//--- src/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
    parameter type entry_t = dcache_pkg::word_t,
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic                     we,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // read is combinational
    assign rdata = mem[raddr];

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DC_WORD_W-1:0]      word_t;
    typedef logic [`DC_BYTES-1:0]       strobe_t;
    typedef logic [`DC_TAG_BITS-1:0]    tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]  index_t;
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    typedef logic [`DC_WAY_BITS-1:0]    way_t;

    // word address inside the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } meta_entry_t;

    typedef meta_entry_t [`DC_WAYS-1:0] meta_set_t;

    typedef logic [`DC_WAYS-2:0] plru_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dcache_response.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_response (
    input  logic              clk,
    input  logic              resetn,
    input  logic              hit_accept,
    input  dcache_pkg::word_t hit_word,
    output logic              resp_valid,
    output dcache_pkg::word_t resp_rdata,
    input  logic              resp_ready,
    output logic              resp_free
);

    dcache_pkg::word_t held_word;

    // empty, or draining this cycle
    assign resp_free  = !resp_valid || resp_ready;
    assign resp_rdata = held_word;

    always_ff @(posedge clk) begin
        if (resetn) begin
            resp_valid <= 1'b0;
        end else if (hit_accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_accept) begin
            held_word <= hit_word;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   req_valid,
    input  logic [`DC_ADDR_W-1:0]  req_addr,
    input  logic                   req_write,
    input  logic [`DC_BYTES-1:0]   req_strobe,
    input  logic [`DC_WORD_W-1:0]  req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [`DC_WORD_W-1:0]  resp_rdata,
    input  logic                   resp_ready,
    output logic                   mem_req_valid,
    output logic                   mem_req_write,
    output logic [`DC_ADDR_W-1:0]  mem_req_addr,
    output logic [`DC_WORD_W-1:0]  mem_wdata,
    input  logic                   mem_ready,
    input  logic [`DC_WORD_W-1:0]  mem_rdata,
    input  logic                   mem_last
);

    localparam int META_W      = `DC_WAYS * (`DC_TAG_BITS + 2);
    localparam int DATA_ADDR_W = `DC_WAY_BITS + `DC_INDEX_BITS + `DC_OFFSET_BITS;
    localparam int DATA_DEPTH  = `DC_WAYS * `DC_SETS * `DC_WORDS_PER_LINE;

    logic [`DC_INDEX_BITS-1:0]  index;
    logic [`DC_OFFSET_BITS-1:0] offset;
    logic [`DC_TAG_BITS-1:0]    tag;
    logic                       hit;
    logic [`DC_WAY_BITS-1:0]    hit_way;
    logic [`DC_WAYS-1:0]        valid_ways;
    logic [`DC_WAY_BITS-1:0]    victim;
    logic [META_W-1:0]          meta;
    logic [META_W-1:0]          meta_wdata;
    logic                       meta_we;
    logic [DATA_ADDR_W-1:0]     data_addr;
    logic                       data_we;
    logic [`DC_WORD_W-1:0]      data_wdata;
    logic [`DC_WORD_W-1:0]      data_rdata;
    logic                       plru_touch;
    logic [`DC_WAY_BITS-1:0]    plru_way;
    logic                       hit_accept;
    logic [`DC_WORD_W-1:0]      hit_word;
    logic                       resp_free;

    tag_lookup i_tag_lookup (.*);

    miss_controller i_miss_controller (.*);

    dcache_response i_dcache_response (.*);

    plru_tree i_plru_tree (
        .clk        (clk),
        .resetn     (resetn),
        .index      (index),
        .valid_ways (valid_ways),
        .touch      (plru_touch),
        .touch_way  (plru_way),
        .victim     (victim)
    );

    cache_ram #(
        .entry_t (logic [META_W-1:0]),
        .DEPTH   (`DC_SETS)
    ) meta_ram (
        .clk    (clk),
        .resetn (resetn),
        .raddr  (index),
        .waddr  (index),
        .we     (meta_we),
        .wdata  (meta_wdata),
        .rdata  (meta)
    );

    cache_ram #(
        .entry_t (logic [`DC_WORD_W-1:0]),
        .DEPTH   (DATA_DEPTH)
    ) data_ram (
        .clk    (clk),
        .resetn (resetn),
        .raddr  (data_addr),
        .waddr  (data_addr),
        .we     (data_we),
        .wdata  (data_wdata),
        .rdata  (data_rdata)
    );

endmodule

`default_nettype wire

//--- src/miss_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module miss_controller (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  dcache_pkg::strobe_t     req_strobe,
    input  dcache_pkg::word_t       req_wdata,
    output logic                    req_ready,
    input  dcache_pkg::index_t      index,
    input  dcache_pkg::offset_t     offset,
    input  dcache_pkg::tag_t        tag,
    input  logic                    hit,
    input  dcache_pkg::way_t        hit_way,
    input  dcache_pkg::meta_set_t   meta,
    input  dcache_pkg::way_t        victim,
    input  logic                    resp_free,
    output logic                    meta_we,
    output dcache_pkg::meta_set_t   meta_wdata,
    output dcache_pkg::data_addr_t  data_addr,
    output logic                    data_we,
    output dcache_pkg::word_t       data_wdata,
    input  dcache_pkg::word_t       data_rdata,
    output logic                    plru_touch,
    output dcache_pkg::way_t        plru_way,
    output logic                    hit_accept,
    output dcache_pkg::word_t       hit_word,
    output logic                    mem_req_valid,
    output logic                    mem_req_write,
    output logic [`DC_ADDR_W-1:0]   mem_req_addr,
    output dcache_pkg::word_t       mem_wdata,
    input  logic                    mem_ready,
    input  logic                    mem_last,
    input  dcache_pkg::word_t       mem_rdata
);

    function automatic dcache_pkg::word_t merge_bytes(
        input dcache_pkg::word_t   old_word,
        input dcache_pkg::word_t   new_word,
        input dcache_pkg::strobe_t strobe
    );
        dcache_pkg::word_t result;
        result = old_word;
        for (int b = 0; b < `DC_BYTES; b++) begin
            if (strobe[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::offset_t     beat;
    dcache_pkg::way_t        fill_way;
    dcache_pkg::word_t       merged;
    dcache_pkg::tag_t        line_tag;
    logic                    idle;
    logic                    miss;
    logic                    burst_done;
    logic                    store_hit;

    assign idle       = (state == dcache_pkg::IDLE);
    assign req_ready  = idle && hit && resp_free;
    assign hit_accept = req_valid && req_ready;
    assign store_hit  = hit_accept && req_write;
    assign miss       = idle && req_valid && !hit;
    assign burst_done = mem_ready && mem_last;

    assign merged     = merge_bytes(data_rdata, req_wdata, req_strobe);
    assign hit_word   = req_write ? merged : data_rdata;
    assign plru_touch = hit_accept;
    assign plru_way   = hit_way;

    // idle serves the hit word, otherwise the current beat of the victim line
    always_comb begin
        data_addr.index = index;
        if (idle) begin
            data_addr.way    = hit_way;
            data_addr.offset = offset;
        end else begin
            data_addr.way    = fill_way;
            data_addr.offset = beat;
        end
    end

    assign data_we    = idle ? store_hit : ((state == dcache_pkg::REFILL) && mem_ready);
    assign data_wdata = idle ? merged : mem_rdata;

    always_comb begin
        meta_wdata = meta;
        if (idle) begin
            meta_wdata[hit_way].dirty = 1'b1;
        end else begin
            meta_wdata[fill_way].valid = 1'b1;
            meta_wdata[fill_way].dirty = 1'b0;
            meta_wdata[fill_way].tag   = tag;
        end
    end

    assign meta_we = idle ? store_hit : ((state == dcache_pkg::REFILL) && burst_done);

    // writeback goes out under the victim's old tag
    assign line_tag      = (state == dcache_pkg::WRITEBACK) ? meta[fill_way].tag : tag;
    assign mem_req_valid = !idle;
    assign mem_req_write = (state == dcache_pkg::WRITEBACK);
    assign mem_req_addr  = {line_tag, index, {(`DC_OFFSET_BITS + `DC_ALIGN_BITS){1'b0}}};
    assign mem_wdata     = data_rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= dcache_pkg::IDLE;
            beat  <= '0;
        end else begin
            if (!idle && mem_ready) begin
                beat <= burst_done ? '0 : beat + 1'b1;
            end
            unique case (state)
                dcache_pkg::IDLE: begin
                    if (miss) begin
                        state <= (meta[victim].valid && meta[victim].dirty) ?
                                 dcache_pkg::WRITEBACK : dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::WRITEBACK: begin
                    if (burst_done) begin
                        state <= dcache_pkg::REFILL;
                    end
                end
                dcache_pkg::REFILL: begin
                    if (burst_done) begin
                        state <= dcache_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    // victim way held for the whole miss
    always_ff @(posedge clk) begin
        if (miss) begin
            fill_way <= victim;
        end
    end

endmodule

`default_nettype wire

//--- src/plru_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module plru_tree (
    input  logic                clk,
    input  logic                resetn,
    input  dcache_pkg::index_t  index,
    input  logic [`DC_WAYS-1:0] valid_ways,
    input  logic                touch,
    input  dcache_pkg::way_t    touch_way,
    output dcache_pkg::way_t    victim
);

    dcache_pkg::plru_t tree_bits [`DC_SETS];
    dcache_pkg::plru_t cur_bits;
    dcache_pkg::way_t  tree_way;

    assign cur_bits = tree_bits[index];

    // bit 0 picks the half, bit 1 the left pair, bit 2 the right pair
    assign tree_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

    // lowest invalid way wins over the tree
    always_comb begin
        victim = tree_way;
        for (int i = `DC_WAYS - 1; i >= 0; i--) begin
            if (!valid_ways[i]) begin
                victim = dcache_pkg::way_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                tree_bits[s] <= '0;
            end
        end else if (touch) begin
            tree_bits[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_bits[index][2] <= ~touch_way[0];
            end else begin
                tree_bits[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module tag_lookup (
    input  logic [`DC_ADDR_W-1:0] req_addr,
    input  dcache_pkg::meta_set_t meta,
    output dcache_pkg::index_t    index,
    output dcache_pkg::offset_t   offset,
    output dcache_pkg::tag_t      tag,
    output logic                  hit,
    output dcache_pkg::way_t      hit_way,
    output logic [`DC_WAYS-1:0]   valid_ways
);

    localparam int OFFSET_LSB = `DC_ALIGN_BITS;
    localparam int INDEX_LSB  = OFFSET_LSB + `DC_OFFSET_BITS;
    localparam int TAG_LSB    = INDEX_LSB + `DC_INDEX_BITS;

    logic [`DC_WAYS-1:0] match;

    // byte-in-word bits are not needed here
    assign offset = req_addr[OFFSET_LSB +: `DC_OFFSET_BITS];
    assign index  = req_addr[INDEX_LSB +: `DC_INDEX_BITS];
    assign tag    = req_addr[TAG_LSB +: `DC_TAG_BITS];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            valid_ways[w] = meta[w].valid;
            match[w]      = meta[w].valid && (meta[w].tag == tag);
        end
    end

    assign hit = |match;

    // at most one way matches, so or-ing the indices encodes it
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (match[w]) begin
                hit_way = hit_way | dcache_pkg::way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire
